/* verilog/mem_pkg.sv */
package mem_pkg;

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int STRB_W    = 4;
	localparam int MEM_WORDS = 256; // byte addr >= 4*MEM_WORDS is out of range
	localparam int NUM_PORTS = 2;

	// same codes as the core's load/store decode
	typedef enum logic [2:0] {
		OP_NONE = 3'd0,
		OP_LB   = 3'd1,
		OP_LH   = 3'd2,
		OP_LW   = 3'd3,
		OP_SB   = 3'd4,
		OP_SH   = 3'd5,
		OP_SW   = 3'd6
	} mem_op_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_t;

	typedef enum logic [1:0] {ARB_IDLE, ARB_READ, ARB_WRITE} arb_state_t;

	typedef enum logic [1:0] {LSU_IDLE, LSU_ADDR, LSU_RESP} lsu_state_t;

endpackage

/* verilog/axi_lite_if.sv */
`timescale 1ns/1ps

interface axi_lite_if;
	import mem_pkg::*;

	// read address / data
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [DATA_W-1:0] rdata;
	axi_resp_t         rresp;
	logic              rvalid;
	logic              rready;

	// write address / data / response
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;
	axi_resp_t         bresp;
	logic              bvalid;
	logic              bready;

	modport master (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport slave (
		input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

endinterface

/* verilog/lsu_axi_master.sv */
`timescale 1ns/1ps

module lsu_axi_master (
	input  logic                        axi_aclk_i,
	input  logic                        axi_aresetn_i,
	input  logic                        req_i,
	input  mem_pkg::mem_op_t            op_i,
	input  logic [mem_pkg::ADDR_W-1:0]  addr_i,
	input  logic [mem_pkg::DATA_W-1:0]  wdata_i,
	output logic                        done_o,
	output logic [mem_pkg::DATA_W-1:0]  rdata_o,
	output logic                        err_o,
	axi_lite_if.master                  bus
);
	import mem_pkg::*;

	lsu_state_t        state_q;
	logic              arvalid_q, awvalid_q, wvalid_q;
	logic              done_q, err_q;
	logic [ADDR_W-1:0] addr_q;
	mem_op_t           op_q;
	logic [DATA_W-1:0] wdata_q, rdata_q;
	logic [STRB_W-1:0] wstrb_q;
	logic [DATA_W-1:0] wdata_d;
	logic [STRB_W-1:0] wstrb_d;
	logic              ar_hs, aw_hs, w_hs, r_hs, b_hs;
	logic              addr_pend, start, misaligned;

	// pick the addressed byte/half out of the word and sign-extend it
	function automatic logic [DATA_W-1:0] load_fmt(mem_op_t op, logic [1:0] off,
		logic [DATA_W-1:0] d);
		logic [7:0]  b;
		logic [15:0] h;
		b = d[{off, 3'b000} +: 8];
		h = off[1] ? d[31:16] : d[15:0];
		case (op)
			OP_LB:   return {{24{b[7]}}, b};
			OP_LH:   return {{16{h[15]}}, h};
			default: return d;
		endcase
	endfunction

	assign start = req_i && (op_i != OP_NONE) && (state_q == LSU_IDLE);

	assign ar_hs = bus.arvalid && bus.arready;
	assign aw_hs = bus.awvalid && bus.awready;
	assign w_hs  = bus.wvalid && bus.wready;
	assign r_hs  = bus.rvalid && bus.rready;
	assign b_hs  = bus.bvalid && bus.bready;

	// anything still waiting for its handshake after this edge
	assign addr_pend = (arvalid_q && !ar_hs) || (awvalid_q && !aw_hs) || (wvalid_q && !w_hs);

	// lane placement and strobe
	always_comb begin
		wdata_d = wdata_i;
		wstrb_d = '1;
		case (op_i)
			OP_SB: begin
				wdata_d = {4{wdata_i[7:0]}};
				wstrb_d = STRB_W'(1) << addr_i[1:0];
			end
			OP_SH: begin
				wdata_d = {2{wdata_i[15:0]}};
				wstrb_d = addr_i[1] ? 4'b1100 : 4'b0011;
			end
			default: ;
		endcase
	end

	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			state_q   <= LSU_IDLE;
			arvalid_q <= 1'b0;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			done_q    <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				LSU_IDLE: if (start) begin
					state_q <= LSU_ADDR;
					if (op_i inside {OP_LB, OP_LH, OP_LW}) begin
						arvalid_q <= 1'b1;
					end else begin
						awvalid_q <= 1'b1;
						wvalid_q  <= 1'b1;
					end
				end
				LSU_ADDR: begin
					if (ar_hs) arvalid_q <= 1'b0;
					if (aw_hs) awvalid_q <= 1'b0; // aw and w may finish apart
					if (w_hs)  wvalid_q  <= 1'b0;
					if (!addr_pend) state_q <= LSU_RESP;
				end
				LSU_RESP: if (r_hs || b_hs) begin
					done_q  <= 1'b1;
					err_q   <= r_hs ? (bus.rresp == RESP_SLVERR) : (bus.bresp == RESP_SLVERR);
					state_q <= LSU_IDLE;
				end
				default: state_q <= LSU_IDLE;
			endcase
		end
	end

	always_ff @(posedge axi_aclk_i) begin
		if (start) begin
			addr_q  <= addr_i;
			op_q    <= op_i;
			wdata_q <= wdata_d;
			wstrb_q <= wstrb_d;
		end
		if (r_hs) rdata_q <= load_fmt(op_q, addr_q[1:0], bus.rdata);
		else if (b_hs) rdata_q <= '0;
	end

	assign bus.araddr  = addr_q;
	assign bus.arvalid = arvalid_q;
	assign bus.awaddr  = addr_q;
	assign bus.awvalid = awvalid_q;
	assign bus.wdata   = wdata_q;
	assign bus.wstrb   = wstrb_q;
	assign bus.wvalid  = wvalid_q;
	assign bus.rready  = (state_q == LSU_RESP);
	assign bus.bready  = (state_q == LSU_RESP);

	assign done_o  = done_q;
	assign rdata_o = rdata_q;
	assign err_o   = err_q;

	assign misaligned = ((op_i inside {OP_LH, OP_SH}) && addr_i[0]) ||
		((op_i inside {OP_LW, OP_SW}) && (addr_i[1:0] != 2'b00));

	a_aligned: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		req_i |-> !misaligned);
	a_req_idle: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		req_i |-> state_q == LSU_IDLE); // no queueing, caller waits for done
	a_ar_hold: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		bus.arvalid && !bus.arready |=> bus.arvalid);

endmodule

/* verilog/axi_lite_arbiter.sv */
`timescale 1ns/1ps

module axi_lite_arbiter (
	input  logic       axi_aclk_i,
	input  logic       axi_aresetn_i,
	axi_lite_if.slave  m0,
	axi_lite_if.slave  m1,
	axi_lite_if.master s
);
	import mem_pkg::*;

	arb_state_t                     state_q;
	logic [$clog2(NUM_PORTS)-1:0]   last_q; // last served, also the locked grant
	logic [$clog2(NUM_PORTS)-1:0]   pick, sel;
	logic                           m0_req, m1_req;

	assign m0_req = m0.arvalid || (m0.awvalid && m0.wvalid);
	assign m1_req = m1.arvalid || (m1.awvalid && m1.wvalid);

	// on a tie go to the port not served last
	assign pick = (m0_req && m1_req) ? ~last_q : m1_req;
	assign sel  = (state_q == ARB_IDLE) ? pick : last_q;

	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			state_q <= ARB_IDLE;
			last_q  <= '1; // port 0 wins the first tie
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (s.arvalid && s.arready) begin
						state_q <= ARB_READ;
						last_q  <= sel;
					end else if (s.awvalid && s.awready) begin
						state_q <= ARB_WRITE;
						last_q  <= sel;
					end
				end
				ARB_READ:  if (s.rvalid && s.rready) state_q <= ARB_IDLE;
				ARB_WRITE: if (s.bvalid && s.bready) state_q <= ARB_IDLE;
				default:   state_q <= ARB_IDLE;
			endcase
		end
	end

	// data path, no added cycles
	always_comb begin
		m0.arready = 1'b0;
		m0.awready = 1'b0;
		m0.wready  = 1'b0;
		m0.rvalid  = 1'b0;
		m0.bvalid  = 1'b0;
		m1.arready = 1'b0;
		m1.awready = 1'b0;
		m1.wready  = 1'b0;
		m1.rvalid  = 1'b0;
		m1.bvalid  = 1'b0;
		m0.rdata   = s.rdata;
		m0.rresp   = s.rresp;
		m0.bresp   = s.bresp;
		m1.rdata   = s.rdata;
		m1.rresp   = s.rresp;
		m1.bresp   = s.bresp;
		if (sel == '0) begin
			s.araddr   = m0.araddr;
			s.arvalid  = m0.arvalid;
			s.rready   = m0.rready;
			s.awaddr   = m0.awaddr;
			s.awvalid  = m0.awvalid;
			s.wdata    = m0.wdata;
			s.wstrb    = m0.wstrb;
			s.wvalid   = m0.wvalid;
			s.bready   = m0.bready;
			m0.arready = s.arready;
			m0.awready = s.awready;
			m0.wready  = s.wready;
			m0.rvalid  = s.rvalid;
			m0.bvalid  = s.bvalid;
		end else begin
			s.araddr   = m1.araddr;
			s.arvalid  = m1.arvalid;
			s.rready   = m1.rready;
			s.awaddr   = m1.awaddr;
			s.awvalid  = m1.awvalid;
			s.wdata    = m1.wdata;
			s.wstrb    = m1.wstrb;
			s.wvalid   = m1.wvalid;
			s.bready   = m1.bready;
			m1.arready = s.arready;
			m1.awready = s.awready;
			m1.wready  = s.wready;
			m1.rvalid  = s.rvalid;
			m1.bvalid  = s.bvalid;
		end
	end

	// locked grant stays on the port that waits for the response
	a_grant_locked: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		state_q != ARB_IDLE |->
		(sel ? (m1.rready && m1.bready) : (m0.rready && m0.bready)));

endmodule

/* verilog/axi_lite_sram.sv */
`timescale 1ns/1ps

module axi_lite_sram (
	input  logic      axi_aclk_i,
	input  logic      axi_aresetn_i,
	axi_lite_if.slave bus
);
	import mem_pkg::*;

	logic [DATA_W-1:0]            mem [MEM_WORDS];
	logic [$clog2(MEM_WORDS)-1:0] rd_idx, wr_idx;
	logic                         rd_in_range, wr_in_range;
	logic                         idle_q, rvalid_q, bvalid_q;
	logic                         rvalid_d, bvalid_d;
	logic                         ar_hs, wr_accept;
	logic [DATA_W-1:0]            rdata_q;
	axi_resp_t                    rresp_q, bresp_q;

	assign rd_idx      = bus.araddr[2 +: $clog2(MEM_WORDS)];
	assign wr_idx      = bus.awaddr[2 +: $clog2(MEM_WORDS)];
	assign rd_in_range = bus.araddr < ADDR_W'(4 * MEM_WORDS);
	assign wr_in_range = bus.awaddr < ADDR_W'(4 * MEM_WORDS);

	assign ar_hs     = bus.arvalid && idle_q;
	// aw and w taken together, reads first
	assign wr_accept = idle_q && bus.awvalid && bus.wvalid && !bus.arvalid;

	always_comb begin
		rvalid_d = ar_hs || (rvalid_q && !bus.rready);
		bvalid_d = wr_accept || (bvalid_q && !bus.bready);
	end

	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			idle_q   <= 1'b0;
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			idle_q   <= !rvalid_d && !bvalid_d; // ready again once the response is gone
			rvalid_q <= rvalid_d;
			bvalid_q <= bvalid_d;
		end
	end

	always_ff @(posedge axi_aclk_i) begin
		if (ar_hs) begin
			rdata_q <= rd_in_range ? mem[rd_idx] : '0;
			rresp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
		end
		if (wr_accept) begin
			bresp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
			if (wr_in_range) begin
				for (int i = 0; i < STRB_W; i++) begin
					if (bus.wstrb[i]) mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
		end
	end

	assign bus.arready = idle_q;
	assign bus.awready = wr_accept;
	assign bus.wready  = wr_accept;
	assign bus.rdata   = rdata_q;
	assign bus.rresp   = rresp_q;
	assign bus.rvalid  = rvalid_q;
	assign bus.bresp   = bresp_q;
	assign bus.bvalid  = bvalid_q;

	a_one_resp: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		!(bus.rvalid && bus.bvalid));

endmodule

/* verilog/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic                        axi_aclk_i,
	input  logic                        axi_aresetn_i,
	input  logic                        p0_req_i,
	input  mem_pkg::mem_op_t            p0_op_i,
	input  logic [mem_pkg::ADDR_W-1:0]  p0_addr_i,
	input  logic [mem_pkg::DATA_W-1:0]  p0_wdata_i,
	output logic                        p0_done_o,
	output logic [mem_pkg::DATA_W-1:0]  p0_rdata_o,
	output logic                        p0_err_o,
	input  logic                        p1_req_i,
	input  mem_pkg::mem_op_t            p1_op_i,
	input  logic [mem_pkg::ADDR_W-1:0]  p1_addr_i,
	input  logic [mem_pkg::DATA_W-1:0]  p1_wdata_i,
	output logic                        p1_done_o,
	output logic [mem_pkg::DATA_W-1:0]  p1_rdata_o,
	output logic                        p1_err_o
);

	axi_lite_if m_bus0 ();
	axi_lite_if m_bus1 ();
	axi_lite_if s_bus ();

	lsu_axi_master u_lsu0 (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.req_i         (p0_req_i),
		.op_i          (p0_op_i),
		.addr_i        (p0_addr_i),
		.wdata_i       (p0_wdata_i),
		.done_o        (p0_done_o),
		.rdata_o       (p0_rdata_o),
		.err_o         (p0_err_o),
		.bus           (m_bus0)
	);

	lsu_axi_master u_lsu1 (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.req_i         (p1_req_i),
		.op_i          (p1_op_i),
		.addr_i        (p1_addr_i),
		.wdata_i       (p1_wdata_i),
		.done_o        (p1_done_o),
		.rdata_o       (p1_rdata_o),
		.err_o         (p1_err_o),
		.bus           (m_bus1)
	);

	axi_lite_arbiter u_arb (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.m0            (m_bus0),
		.m1            (m_bus1),
		.s             (s_bus)
	);

	axi_lite_sram u_sram (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.bus           (s_bus)
	);

endmodule

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;
	import mem_pkg::*;

	logic              clk;
	logic              rst;
	logic              req [2];
	mem_op_t           op [2];
	logic [ADDR_W-1:0] addr [2];
	logic [DATA_W-1:0] wdata [2];
	logic              done [2];
	logic [DATA_W-1:0] rdata [2];
	logic              err [2];

	logic [7:0]        ref_mem [logic [31:0]]; // byte model of the sram
	int                last_port;              // port served most recently

	mem_subsys_top dut0 (
		.axi_aclk_i    (clk),
		.axi_aresetn_i (rst),
		.p0_req_i      (req[0]),
		.p0_op_i       (op[0]),
		.p0_addr_i     (addr[0]),
		.p0_wdata_i    (wdata[0]),
		.p0_done_o     (done[0]),
		.p0_rdata_o    (rdata[0]),
		.p0_err_o      (err[0]),
		.p1_req_i      (req[1]),
		.p1_op_i       (op[1]),
		.p1_addr_i     (addr[1]),
		.p1_wdata_i    (wdata[1]),
		.p1_done_o     (done[1]),
		.p1_rdata_o    (rdata[1]),
		.p1_err_o      (err[1])
	);

	always #4 clk = ~clk;

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: at %0t %s got %h expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic logic in_range(logic [31:0] a);
		return a < 32'(4 * MEM_WORDS);
	endfunction

	function automatic logic [31:0] rand_addr();
		return 32'(($urandom % MEM_WORDS) * 4);
	endfunction

	task automatic model_store(mem_op_t o, logic [31:0] a, logic [31:0] d);
		int nbytes;
		nbytes = (o == OP_SB) ? 1 : (o == OP_SH) ? 2 : 4;
		if (in_range(a)) begin
			for (int i = 0; i < nbytes; i++) ref_mem[a + i] = d[8*i +: 8]; // little endian
		end
	endtask

	function automatic logic [31:0] model_load(mem_op_t o, logic [31:0] a);
		case (o)
			OP_LB:   return {{24{ref_mem[a][7]}}, ref_mem[a]};
			OP_LH:   return {{16{ref_mem[a + 1][7]}}, ref_mem[a + 1], ref_mem[a]};
			default: return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
		endcase
	endfunction

	task automatic drive_req(int p, mem_op_t o, logic [31:0] a, logic [31:0] d);
		req[p]   = 1'b1;
		op[p]    = o;
		addr[p]  = a;
		wdata[p] = d;
	endtask

	task automatic clear_req(int p);
		req[p] = 1'b0;
		op[p]  = OP_NONE;
	endtask

	task automatic wait_done(int p, output logic [31:0] rd, output logic e);
		int n;
		n = 0;
		while (!done[p]) begin
			if (n == 100) begin
				$display("Timeout: port %0d never completed its request", p);
				$display("Simulation failed");
				$fatal(1);
			end
			@(negedge clk);
			n++;
		end
		rd = rdata[p];
		e  = err[p];
	endtask

	task automatic access(int p, mem_op_t o, logic [31:0] a, logic [31:0] d,
		output logic [31:0] rd, output logic e);
		drive_req(p, o, a, d);
		@(negedge clk);
		clear_req(p); // one cycle strobe
		wait_done(p, rd, e);
		last_port = p;
	endtask

	task automatic store(int p, mem_op_t o, logic [31:0] a, logic [31:0] d);
		logic [31:0] rd;
		logic        e;
		access(p, o, a, d, rd, e);
		check($sformatf("p%0d_err_o", p), 32'(e), 32'(!in_range(a)));
		model_store(o, a, d);
	endtask

	task automatic load_check(int p, mem_op_t o, logic [31:0] a);
		logic [31:0] rd;
		logic        e;
		access(p, o, a, 32'h0, rd, e);
		check($sformatf("p%0d_err_o", p), 32'(e), 32'h0);
		check($sformatf("p%0d_rdata_o", p), rd, model_load(o, a));
	endtask

	// both ports strobe in the same cycle, tie goes to the port not served last
	task automatic run_pair(mem_op_t o, logic [31:0] a0, logic [31:0] a1,
		logic [31:0] d0, logic [31:0] d1);
		logic [31:0] rd [2];
		logic        e [2];
		logic        seen [2];
		int          first, expect_first, n;
		expect_first = 1 - last_port;
		seen[0] = 1'b0;
		seen[1] = 1'b0;
		first = -1;
		n = 0;
		drive_req(0, o, a0, d0);
		drive_req(1, o, a1, d1);
		@(negedge clk);
		clear_req(0);
		clear_req(1);
		while (!(seen[0] && seen[1])) begin
			if (n == 100) begin
				$display("Timeout: port %0d never completed its request", seen[0] ? 1 : 0);
				$display("Simulation failed");
				$fatal(1);
			end
			@(negedge clk);
			n++;
			for (int p = 0; p < 2; p++) begin
				if (done[p] && !seen[p]) begin
					seen[p] = 1'b1;
					rd[p]   = rdata[p];
					e[p]    = err[p];
					if (first < 0) first = p;
				end
			end
		end
		check("first done port", first, expect_first);
		last_port = 1 - first;
		check("p0_err_o", 32'(e[0]), 32'h0);
		check("p1_err_o", 32'(e[1]), 32'h0);
		if (o inside {OP_SB, OP_SH, OP_SW}) begin
			model_store(o, a0, d0);
			model_store(o, a1, d1);
		end else begin
			check("p0_rdata_o", rd[0], model_load(o, a0));
			check("p1_rdata_o", rd[1], model_load(o, a1));
		end
	endtask

	task automatic test_word_rw();
		logic [31:0] a;
		for (int k = 0; k < 8; k++) begin
			a = rand_addr();
			store(0, OP_SW, a, $urandom);
			load_check(0, OP_LW, a);
		end
	endtask

	task automatic test_partial_store();
		logic [31:0] a;
		a = rand_addr();
		for (int off = 0; off < 4; off++) begin
			store(0, OP_SW, a, $urandom);
			store(0, OP_SB, a + off, $urandom);
			load_check(0, OP_LW, a);
		end
		for (int off = 0; off < 4; off += 2) begin
			store(0, OP_SW, a, $urandom);
			store(0, OP_SH, a + off, $urandom);
			load_check(0, OP_LW, a);
		end
	endtask

	task automatic test_sign_extend();
		logic [31:0] a;
		logic [31:0] pat [3];
		pat[0] = 32'h80ff_7f01;
		pat[1] = 32'h7fff_8000;
		pat[2] = $urandom;
		a = rand_addr();
		for (int k = 0; k < 3; k++) begin
			store(0, OP_SW, a, pat[k]);
			for (int off = 0; off < 4; off++) load_check(0, OP_LB, a + off);
			for (int off = 0; off < 4; off += 2) load_check(0, OP_LH, a + off);
		end
	endtask

	task automatic test_out_of_range();
		logic [31:0] a, rd;
		logic        e;
		a = rand_addr();
		store(0, OP_SW, a, $urandom);
		store(0, OP_SW, a + 4 * MEM_WORDS, $urandom); // same word index, must not land
		store(0, OP_SB, 32'hffff_fff1, $urandom);
		access(0, OP_LW, a + 4 * MEM_WORDS, 32'h0, rd, e);
		check("p0_err_o", 32'(e), 32'h1);
		load_check(0, OP_LW, a);
	endtask

	task automatic test_round_robin();
		logic [31:0] a0, a1;
		a0 = rand_addr();
		a1 = (a0 + 4) % (4 * MEM_WORDS);
		run_pair(OP_SW, a0, a1, $urandom, $urandom);
		run_pair(OP_LW, a0, a1, 32'h0, 32'h0);
		run_pair(OP_LW, a1, a0, 32'h0, 32'h0);
		// a solo access by the last winner hands the next tie to the other port
		store(1 - last_port, OP_SW, a0, $urandom);
		run_pair(OP_LW, a0, a1, 32'h0, 32'h0);
		store(1 - last_port, OP_SW, a1, $urandom);
		run_pair(OP_LW, a0, a1, 32'h0, 32'h0);
	endtask

	task automatic test_cross_port();
		logic [31:0] a;
		a = rand_addr();
		store(0, OP_SW, a, $urandom);
		store(1, OP_SW, a, $urandom);
		load_check(0, OP_LW, a); // right after port 1 done
		store(1, OP_SB, a + 3, 32'h9c);
		load_check(0, OP_LB, a + 3);
	endtask

	initial begin
		void'($urandom(81598));
		clk = 1'b0;
		rst = 1'b1;
		last_port = 1;
		for (int p = 0; p < 2; p++) begin
			req[p]   = 1'b0;
			op[p]    = OP_NONE;
			addr[p]  = '0;
			wdata[p] = '0;
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		test_word_rw();
		test_partial_store();
		test_sign_extend();
		test_out_of_range();
		test_round_robin();
		test_cross_port();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* sources.f */
verilog/mem_pkg.sv
verilog/axi_lite_if.sv
verilog/lsu_axi_master.sv
verilog/axi_lite_arbiter.sv
verilog/axi_lite_sram.sv
verilog/mem_subsys_top.sv
sim/tb_mem_subsys.sv

/* Makefile */
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_mem_subsys: sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_mem_subsys -Mdir obj_dir

run: obj_dir/Vtb_mem_subsys
	./obj_dir/Vtb_mem_subsys | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
